// File: Bender.yml
package:
  name: ac97_ctrl

sources:
  - include_dirs:
      - common
    files:
      - common/ac97_pkg.sv
      - fifo/sample_fifo.sv
      - fifo/fifo_level_monitor.sv
      - hw/sample_clock_gen.sv
      - hw/ac97_bus_ctrl.sv
      - hw/ac97_ctrl_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_ac97_ctrl.sv

// File: common/ac97_consts.svh
`ifndef AC97_CONSTS_SVH
`define AC97_CONSTS_SVH

// ------------------------------------------------------------
// register map, offsets from the block base

`define AC97_REG_FIFO_PLAY   20'h00000  // write only, low 16 bits
`define AC97_REG_FIFO_REC    20'h00004  // read only, low 16 bits
`define AC97_REG_STAT        20'h00008  // read only
`define AC97_REG_FIFO_RESET  20'h0000C  // write only, bit 0 play, bit 1 rec

// status word bit positions, bits 4 and 5 read as zero
`define STAT_PLAY_FULL       0
`define STAT_PLAY_HF         1
`define STAT_REC_FULL        2
`define STAT_REC_EMPTY       3
`define STAT_PLAY_UNDERRUN   6
`define STAT_REC_OVERRUN     7

// bit positions inside a fifo_flags_t vector
`define FLAG_EMPTY           0
`define FLAG_HALFEMPTY       1
`define FLAG_HALFFULL        2
`define FLAG_FULL            3

// ------------------------------------------------------------
// sizes and divider

`define AC97_FIFO_DEPTH      16         // stereo frames per fifo
`define CLK_48KHZ_CTR_MAX    2604       // last count of every run
`define CLK_48KHZ_FRC_MAX    5          // short runs between two long runs

// interrupt level codes
`define IRQ_LVL_NONE         0
`define IRQ_LVL_EMPTY        1          // count == 0
`define IRQ_LVL_HALFEMPTY    2          // count <= 7
`define IRQ_LVL_HALFFULL     3          // count >= 8
`define IRQ_LVL_FULL         4          // count == 16

`endif

// File: common/ac97_pkg.sv
package ac97_pkg;

  //------------------------------------------------------------
  // audio payload

  typedef logic [15:0] sample_t;             // one audio sample, signed pcm
  typedef logic [31:0] frame_t;              // stereo frame, left in [15:0]

  //------------------------------------------------------------
  // system bus

  typedef logic [19:0] bus_addr_t;           // register offset inside the block
  typedef logic [31:0] bus_data_t;           // bus word, read and write

  //------------------------------------------------------------
  // fifo bookkeeping

  typedef logic [4:0]  fifo_count_t;         // fill level 0..16
  typedef logic [3:0]  fifo_flags_t;         // empty, half-empty, half-full, full

endpackage

// File: fifo/fifo_level_monitor.sv
`timescale 1ns/1ps
`include "ac97_consts.svh"

module fifo_level_monitor #(
  parameter int IRQ_LEVEL    = `IRQ_LVL_NONE,   // one of the IRQ_LVL_ codes
  parameter bit XRUN_ON_FULL = 1'b0             // 0 underrun, 1 overrun
) (
  input  logic                  clk_adc_125mhz, // adc clock, 125 mhz
  input  logic                  adc_rstn_i,     // sync reset, active low
  input  ac97_pkg::fifo_count_t count_i,
  input  logic                  clear_i,        // fifo flush
  input  logic                  tick_i,         // 48k sample tick
  output ac97_pkg::fifo_flags_t flags_o,
  output logic                  irq_o,          // level interrupt
  output logic                  xrun_o          // sticky until flush
);

  ac97_pkg::fifo_flags_t flags_d;               // flags one cycle back
  logic                  sel_now;
  logic                  sel_prev;
  logic                  xrun_cond;

  assign flags_o[`FLAG_EMPTY]     = (count_i == '0);
  assign flags_o[`FLAG_HALFEMPTY] = (count_i < (`AC97_FIFO_DEPTH / 2));
  assign flags_o[`FLAG_HALFFULL]  = (count_i >= (`AC97_FIFO_DEPTH / 2));
  assign flags_o[`FLAG_FULL]      = (count_i == `AC97_FIFO_DEPTH);

  assign xrun_cond = XRUN_ON_FULL ? flags_o[`FLAG_FULL] : flags_o[`FLAG_EMPTY];

  // flag picked by the interrupt level
  always_comb begin
    case (IRQ_LEVEL)
      `IRQ_LVL_EMPTY: begin
        sel_now  = flags_o[`FLAG_EMPTY];
        sel_prev = flags_d[`FLAG_EMPTY];
      end
      `IRQ_LVL_HALFEMPTY: begin
        sel_now  = flags_o[`FLAG_HALFEMPTY];
        sel_prev = flags_d[`FLAG_HALFEMPTY];
      end
      `IRQ_LVL_HALFFULL: begin
        sel_now  = flags_o[`FLAG_HALFFULL];
        sel_prev = flags_d[`FLAG_HALFFULL];
      end
      `IRQ_LVL_FULL: begin
        sel_now  = flags_o[`FLAG_FULL];
        sel_prev = flags_d[`FLAG_FULL];
      end
      default: begin
        sel_now  = 1'b0;                        // IRQ_LVL_NONE, never fires
        sel_prev = 1'b0;
      end
    endcase
  end

  //------------------------------------------------------------
  // edge interrupt and sticky xrun

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      flags_d <= '0;
      irq_o   <= 1'b0;
      xrun_o  <= 1'b0;
    end else begin
      flags_d <= flags_o;
      if (clear_i) begin
        irq_o <= 1'b0;
      end else if (IRQ_LEVEL == `IRQ_LVL_EMPTY) begin
        if (!flags_o[`FLAG_EMPTY]) begin
          irq_o <= 1'b0;                        // refilled
        end else if (sel_now && !sel_prev) begin
          irq_o <= 1'b1;                        // just ran empty
        end
      end else if (flags_o[`FLAG_EMPTY]) begin
        irq_o <= 1'b0;                          // drained
      end else if (sel_now && !sel_prev) begin
        irq_o <= 1'b1;                          // crossed the level
      end

      if (clear_i) begin
        xrun_o <= 1'b0;
      end else if (tick_i && xrun_cond) begin
        xrun_o <= 1'b1;
      end
    end
  end

endmodule

// File: fifo/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo #(
  parameter int DEPTH = 16                      // frames
) (
  input  logic                  clk_adc_125mhz, // adc clock, 125 mhz
  input  logic                  adc_rstn_i,     // sync reset, active low
  input  logic                  clear_i,        // sync flush
  input  logic                  push_i,         // dropped when full
  input  logic                  pop_i,          // dropped when empty
  input  ac97_pkg::frame_t      data_i,
  output ac97_pkg::frame_t      head_o,         // fall-through, zero when empty
  output ac97_pkg::fifo_count_t count_o
);

  localparam int PTR_W = $clog2(DEPTH);

  ac97_pkg::frame_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i && (count_o != DEPTH);
  assign do_pop  = pop_i && (count_o != '0);

  assign head_o = (count_o == '0) ? '0 : mem[rd_ptr];

  // frame storage
  always_ff @(posedge clk_adc_125mhz) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  //------------------------------------------------------------
  // pointers and fill count

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i || clear_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_o <= count_o + 1'b1;
      end else if (do_pop && !do_push) begin
        count_o <= count_o - 1'b1;
      end
    end
  end

endmodule

// File: hw/ac97_bus_ctrl.sv
`timescale 1ns/1ps
`include "ac97_consts.svh"

module ac97_bus_ctrl (
  input  logic                  clk_adc_125mhz,  // adc clock, 125 mhz
  input  logic                  adc_rstn_i,      // sync reset, active low

  input  logic [31:0]           sys_addr_i,      // only [19:0] decoded
  input  ac97_pkg::bus_data_t   sys_wdata_i,
  input  logic [3:0]            sys_sel_i,       // full word access only
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output ac97_pkg::bus_data_t   sys_rdata_o,
  output logic                  sys_err_o,
  output logic                  sys_ack_o,

  output ac97_pkg::frame_t      play_frame_o,    // {right, left}
  output logic                  play_push_o,     // cycle after the right write
  output logic                  play_clear_o,
  output logic                  rec_pop_o,       // in the ack of a right read
  output logic                  rec_clear_o,
  input  ac97_pkg::frame_t      rec_head_i,
  input  ac97_pkg::fifo_flags_t play_flags_i,
  input  ac97_pkg::fifo_flags_t rec_flags_i,
  input  logic                  play_underrun_i,
  input  logic                  rec_overrun_i
);

  ac97_pkg::bus_addr_t reg_addr;
  ac97_pkg::sample_t   play_left;               // holding regs for one frame
  ac97_pkg::sample_t   play_right;
  ac97_pkg::bus_data_t stat_word;
  logic                play_is_right;           // next play write is right
  logic                rec_is_right;            // next rec read is right
  logic                wr_play;
  logic                wr_reset;
  logic                rd_rec;

  //------------------------------------------------------------
  // address decode

  assign reg_addr = sys_addr_i[19:0];
  assign wr_play  = sys_wen_i && (reg_addr == `AC97_REG_FIFO_PLAY);
  assign wr_reset = sys_wen_i && (reg_addr == `AC97_REG_FIFO_RESET);
  assign rd_rec   = sys_ren_i && (reg_addr == `AC97_REG_FIFO_REC);

  assign sys_err_o = 1'b0;                      // no error responses

  //------------------------------------------------------------
  // play frame packing

  always_ff @(posedge clk_adc_125mhz) begin
    if (wr_play && !play_is_right) begin
      play_left <= sys_wdata_i[15:0];
    end
    if (wr_play && play_is_right) begin
      play_right <= sys_wdata_i[15:0];
    end
  end

  assign play_frame_o = {play_right, play_left};

  // status word, unused bits stay zero
  always_comb begin
    stat_word                      = '0;
    stat_word[`STAT_PLAY_FULL]     = play_flags_i[`FLAG_FULL];
    stat_word[`STAT_PLAY_HF]       = play_flags_i[`FLAG_HALFFULL];
    stat_word[`STAT_REC_FULL]      = rec_flags_i[`FLAG_FULL];
    stat_word[`STAT_REC_EMPTY]     = rec_flags_i[`FLAG_EMPTY];
    stat_word[`STAT_PLAY_UNDERRUN] = play_underrun_i;
    stat_word[`STAT_REC_OVERRUN]   = rec_overrun_i;
  end

  //------------------------------------------------------------
  // ack, strobes, phases and read data

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      sys_ack_o     <= 1'b0;
      sys_rdata_o   <= '0;
      play_push_o   <= 1'b0;
      play_clear_o  <= 1'b0;
      rec_pop_o     <= 1'b0;
      rec_clear_o   <= 1'b0;
      play_is_right <= 1'b0;
      rec_is_right  <= 1'b0;
    end else begin
      sys_ack_o    <= sys_wen_i || sys_ren_i;   // never stalls
      play_push_o  <= wr_play && play_is_right;
      play_clear_o <= wr_reset && sys_wdata_i[0];
      rec_clear_o  <= wr_reset && sys_wdata_i[1];
      rec_pop_o    <= rd_rec && rec_is_right;

      if (wr_reset && sys_wdata_i[0]) begin
        play_is_right <= 1'b0;                  // restart with left
      end else if (wr_play) begin
        play_is_right <= !play_is_right;
      end

      if (wr_reset && sys_wdata_i[1]) begin
        rec_is_right <= 1'b0;
      end else if (rd_rec) begin
        rec_is_right <= !rec_is_right;
      end

      if (sys_ren_i) begin
        case (reg_addr)
          `AC97_REG_FIFO_REC: begin
            sys_rdata_o <= {16'h0000, rec_is_right ? rec_head_i[31:16] : rec_head_i[15:0]};
          end
          `AC97_REG_STAT: begin
            sys_rdata_o <= stat_word;
          end
          default: begin
            sys_rdata_o <= '0;                  // write only or unmapped
          end
        endcase
      end
    end
  end

endmodule

// File: hw/ac97_ctrl_top.sv
`timescale 1ns/1ps
`include "ac97_consts.svh"

module ac97_ctrl_top (
  input  logic                clk_adc_125mhz,   // adc clock, 125 mhz
  input  logic                adc_rstn_i,       // sync reset, active low
  output logic [1:0]          ac97_clks_o,      // {48k tick, 8k tick}

  output ac97_pkg::frame_t    ac97_line_out_o,  // play fifo head
  input  ac97_pkg::frame_t    ac97_line_in_i,   // sampled on every 48k tick

  output logic                ac97_irq_play_o,  // play fifo half-empty
  output logic                ac97_irq_rec_o,   // rec fifo half-full

  input  logic [31:0]         sys_addr_i,       // bus address
  input  ac97_pkg::bus_data_t sys_wdata_i,      // bus write data
  input  logic [3:0]          sys_sel_i,        // byte select
  input  logic                sys_wen_i,        // write strobe
  input  logic                sys_ren_i,        // read strobe
  output ac97_pkg::bus_data_t sys_rdata_o,      // read data, valid with ack
  output logic                sys_err_o,        // tied low inside
  output logic                sys_ack_o         // one cycle after a strobe
);

  logic                   tick_48k;
  logic                   tick_8k;

  ac97_pkg::frame_t       play_frame;           // bus ctrl -> play fifo
  logic                   play_push;
  logic                   play_clear;
  ac97_pkg::fifo_count_t  play_count;
  ac97_pkg::fifo_flags_t  play_flags;
  logic                   play_underrun;

  ac97_pkg::frame_t       rec_head;             // rec fifo -> bus ctrl
  logic                   rec_pop;
  logic                   rec_clear;
  ac97_pkg::fifo_count_t  rec_count;
  ac97_pkg::fifo_flags_t  rec_flags;
  logic                   rec_overrun;

  assign ac97_clks_o = {tick_48k, tick_8k};     // ascending rate order

  //------------------------------------------------------------
  // sample rate ticks

  sample_clock_gen u_sample_clock_gen (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .tick_48k_o     (tick_48k),
    .tick_8k_o      (tick_8k)
  );

  //------------------------------------------------------------
  // register interface

  ac97_bus_ctrl u_ac97_bus_ctrl (
    .clk_adc_125mhz  (clk_adc_125mhz),
    .adc_rstn_i      (adc_rstn_i),
    .sys_addr_i      (sys_addr_i),
    .sys_wdata_i     (sys_wdata_i),
    .sys_sel_i       (sys_sel_i),
    .sys_wen_i       (sys_wen_i),
    .sys_ren_i       (sys_ren_i),
    .sys_rdata_o     (sys_rdata_o),
    .sys_err_o       (sys_err_o),
    .sys_ack_o       (sys_ack_o),
    .play_frame_o    (play_frame),
    .play_push_o     (play_push),
    .play_clear_o    (play_clear),
    .rec_pop_o       (rec_pop),
    .rec_clear_o     (rec_clear),
    .rec_head_i      (rec_head),
    .play_flags_i    (play_flags),
    .rec_flags_i     (rec_flags),
    .play_underrun_i (play_underrun),
    .rec_overrun_i   (rec_overrun)
  );

  //------------------------------------------------------------
  // playback side, drained by the 48k tick

  sample_fifo #(.DEPTH(`AC97_FIFO_DEPTH)) u_play_fifo (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .clear_i        (play_clear),
    .push_i         (play_push),
    .pop_i          (tick_48k),
    .data_i         (play_frame),
    .head_o         (ac97_line_out_o),          // zero while empty
    .count_o        (play_count)
  );

  fifo_level_monitor #(
    .IRQ_LEVEL    (`IRQ_LVL_HALFEMPTY),
    .XRUN_ON_FULL (1'b0)                        // underrun on empty
  ) u_play_monitor (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .count_i        (play_count),
    .clear_i        (play_clear),
    .tick_i         (tick_48k),
    .flags_o        (play_flags),
    .irq_o          (ac97_irq_play_o),
    .xrun_o         (play_underrun)
  );

  //------------------------------------------------------------
  // record side, filled by the 48k tick

  sample_fifo #(.DEPTH(`AC97_FIFO_DEPTH)) u_rec_fifo (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .clear_i        (rec_clear),
    .push_i         (tick_48k),
    .pop_i          (rec_pop),
    .data_i         (ac97_line_in_i),
    .head_o         (rec_head),
    .count_o        (rec_count)
  );

  fifo_level_monitor #(
    .IRQ_LEVEL    (`IRQ_LVL_HALFFULL),
    .XRUN_ON_FULL (1'b1)                        // overrun on full
  ) u_rec_monitor (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .count_i        (rec_count),
    .clear_i        (rec_clear),
    .tick_i         (tick_48k),
    .flags_o        (rec_flags),
    .irq_o          (ac97_irq_rec_o),
    .xrun_o         (rec_overrun)
  );

endmodule

// File: hw/sample_clock_gen.sv
`timescale 1ns/1ps
`include "ac97_consts.svh"

module sample_clock_gen (
  input  logic clk_adc_125mhz,  // adc clock, 125 mhz
  input  logic adc_rstn_i,      // sync reset, active low
  output logic tick_48k_o,      // one cycle pulse, 48 khz average
  output logic tick_8k_o        // one cycle pulse on every 6th 48k tick
);

  // 125e6 / 48e3 = 2604.1666, so five runs of 2604 and one of 2605
  logic [11:0] run_ctr;         // position inside the current run
  logic [2:0]  frc_ctr;         // run index, 0 is the long run

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      run_ctr    <= '0;         // first run after reset is a long one
      frc_ctr    <= '0;
      tick_48k_o <= 1'b0;
      tick_8k_o  <= 1'b0;
    end else if (run_ctr == `CLK_48KHZ_CTR_MAX) begin
      tick_48k_o <= 1'b1;
      tick_8k_o  <= (frc_ctr == 3'd0);          // end of the long run
      if (frc_ctr == `CLK_48KHZ_FRC_MAX) begin
        frc_ctr <= '0;
        run_ctr <= 12'd0;                       // long run, 2605 cycles
      end else begin
        frc_ctr <= frc_ctr + 3'd1;
        run_ctr <= 12'd1;                       // short run, 2604 cycles
      end
    end else begin
      tick_48k_o <= 1'b0;
      tick_8k_o  <= 1'b0;
      run_ctr    <= run_ctr + 12'd1;
    end
  end

endmodule

// File: sources.f
+incdir+common
common/ac97_pkg.sv
fifo/sample_fifo.sv
fifo/fifo_level_monitor.sv
hw/sample_clock_gen.sv
hw/ac97_bus_ctrl.sv
hw/ac97_ctrl_top.sv
tests/tb_clock_gen.sv
tests/tb_ac97_ctrl.sv

// File: tests/tb_ac97_ctrl.sv
`timescale 1ns/1ps
`include "ac97_consts.svh"

module tb_ac97_ctrl;

  localparam int DEPTH   = `AC97_FIFO_DEPTH;
  localparam int HALF    = DEPTH / 2;
  localparam int SHORT   = `CLK_48KHZ_CTR_MAX;        // cycles between ticks
  localparam int RUNS    = `CLK_48KHZ_FRC_MAX + 1;    // ticks per 8k period
  localparam int TIMEOUT = 40 * (SHORT + 1) + 10000;  // 40 sample periods plus margin

  logic                clk_adc_125mhz;
  logic                adc_rstn;
  logic [1:0]          ac97_clks;
  ac97_pkg::frame_t    line_out;
  ac97_pkg::frame_t    line_in;
  logic                irq_play;
  logic                irq_rec;
  logic [31:0]         sys_addr;
  ac97_pkg::bus_data_t sys_wdata;
  ac97_pkg::bus_data_t sys_rdata;
  logic [3:0]          sys_sel;
  logic                sys_wen;
  logic                sys_ren;
  logic                sys_err;
  logic                sys_ack;

  //------------------------------------------------------------
  // reference model state

  ac97_pkg::frame_t    play_q[$];               // play fifo contents
  ac97_pkg::frame_t    rec_q[$];                // rec fifo contents
  ac97_pkg::sample_t   play_left_m;             // pending left sample
  logic                play_right_m;            // next play write is right
  logic                rec_right_m;             // next rec read is right
  logic                play_irq_m;
  logic                rec_irq_m;
  logic                underrun_m;
  logic                overrun_m;
  logic [31:0]         rng_state;
  logic                tick_seen;               // 48k tick sampled at last edge
  int unsigned         run_cycles = 0;

  tb_clock_gen u_clock_gen (
    .clk_adc_125mhz_o (clk_adc_125mhz),
    .adc_rstn_o       (adc_rstn)
  );

  ac97_ctrl_top u_ac97_ctrl_top (
    .clk_adc_125mhz  (clk_adc_125mhz),
    .adc_rstn_i      (adc_rstn),
    .ac97_clks_o     (ac97_clks),
    .ac97_line_out_o (line_out),
    .ac97_line_in_i  (line_in),
    .ac97_irq_play_o (irq_play),
    .ac97_irq_rec_o  (irq_rec),
    .sys_addr_i      (sys_addr),
    .sys_wdata_i     (sys_wdata),
    .sys_sel_i       (sys_sel),
    .sys_wen_i       (sys_wen),
    .sys_ren_i       (sys_ren),
    .sys_rdata_o     (sys_rdata),
    .sys_err_o       (sys_err),
    .sys_ack_o       (sys_ack)
  );

  function automatic logic [31:0] lcg(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // play irq fires below half and rec irq at half or above
  function automatic logic next_irq(input logic irq, input int old_n, input int new_n,
                                    input logic is_rec);
    logic old_sel;
    logic new_sel;
    old_sel = is_rec ? (old_n >= HALF) : (old_n < HALF);
    new_sel = is_rec ? (new_n >= HALF) : (new_n < HALF);
    if (new_n == 0) return 1'b0;                // empty fifo drops the irq
    if (new_sel && !old_sel) return 1'b1;
    return irq;
  endfunction

  function automatic ac97_pkg::bus_data_t model_status();
    ac97_pkg::bus_data_t s;
    s                      = '0;
    s[`STAT_PLAY_FULL]     = (play_q.size() == DEPTH);
    s[`STAT_PLAY_HF]       = (play_q.size() >= HALF);
    s[`STAT_REC_FULL]      = (rec_q.size() == DEPTH);
    s[`STAT_REC_EMPTY]     = (rec_q.size() == 0);
    s[`STAT_PLAY_UNDERRUN] = underrun_m;
    s[`STAT_REC_OVERRUN]   = overrun_m;
    return s;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // one sample tick pops or underruns play and pushes or overruns rec
  task automatic apply_tick();
    int old_n;
    old_n = play_q.size();
    if (old_n == 0) underrun_m = 1'b1;
    else play_q.delete(0);
    play_irq_m = next_irq(play_irq_m, old_n, play_q.size(), 1'b0);
    old_n = rec_q.size();
    if (old_n == DEPTH) overrun_m = 1'b1;
    else rec_q.push_back(line_in);
    rec_irq_m = next_irq(rec_irq_m, old_n, rec_q.size(), 1'b1);
  endtask

  // advance one clock and read outputs before the edge updates land
  task automatic step();
    @(posedge clk_adc_125mhz);
    tick_seen = ac97_clks[1];
    if (tick_seen) begin
      apply_tick();
      rng_state = lcg(rng_state);
      line_in  <= rng_state;                    // fresh frame for the next tick
    end
  endtask

  task automatic count_to_tick(output int n);
    n = 0;
    do begin
      step();
      n++;
    end while (!tick_seen);
  endtask

  // single strobe with ack and read data due one cycle later
  task automatic bus_access(input logic is_write, input ac97_pkg::bus_addr_t addr,
                            input ac97_pkg::bus_data_t wdata, input string name,
                            output ac97_pkg::bus_data_t rdata);
    sys_addr  <= {12'h400, addr};               // upper bits are the block base
    sys_wdata <= wdata;
    sys_wen   <= is_write;
    sys_ren   <= !is_write;
    step();
    sys_wen   <= 1'b0;
    sys_ren   <= 1'b0;
    step();
    check_eq({name, " ack"}, 1, sys_ack);
    check_eq({name, " err"}, 0, sys_err);
    rdata = sys_rdata;
  endtask

  task automatic write_play(input ac97_pkg::bus_data_t wdata);
    ac97_pkg::bus_data_t unused;
    int                  old_n;
    bus_access(1'b1, `AC97_REG_FIFO_PLAY, wdata, "play write", unused);
    if (!play_right_m) begin
      play_left_m = wdata[15:0];
    end else begin
      old_n = play_q.size();
      if (old_n < DEPTH) play_q.push_back({wdata[15:0], play_left_m});
      play_irq_m = next_irq(play_irq_m, old_n, play_q.size(), 1'b0);
    end
    play_right_m = !play_right_m;
  endtask

  task automatic read_rec(input string name);
    ac97_pkg::frame_t    head;
    ac97_pkg::bus_data_t expected;
    ac97_pkg::bus_data_t got;
    int                  old_n;
    head     = (rec_q.size() == 0) ? '0 : rec_q[0];
    expected = rec_right_m ? {16'h0000, head[31:16]} : {16'h0000, head[15:0]};
    bus_access(1'b0, `AC97_REG_FIFO_REC, '0, name, got);
    check_eq(name, expected, got);
    old_n = rec_q.size();
    if (rec_right_m && old_n != 0) begin
      rec_q.delete(0);                          // right read frees the frame
      rec_irq_m = next_irq(rec_irq_m, old_n, rec_q.size(), 1'b1);
    end
    rec_right_m = !rec_right_m;
  endtask

  task automatic write_reset(input logic [1:0] bits);
    ac97_pkg::bus_data_t unused;
    bus_access(1'b1, `AC97_REG_FIFO_RESET, {30'h0, bits}, "fifo reset", unused);
    if (bits[0]) begin
      play_q.delete();
      play_irq_m   = 1'b0;
      underrun_m   = 1'b0;
      play_right_m = 1'b0;
    end
    if (bits[1]) begin
      rec_q.delete();
      rec_irq_m   = 1'b0;
      overrun_m   = 1'b0;
      rec_right_m = 1'b0;
    end
  endtask

  task automatic read_status(input string name, output ac97_pkg::bus_data_t stat);
    ac97_pkg::bus_data_t expected;
    expected = model_status();
    bus_access(1'b0, `AC97_REG_STAT, '0, name, stat);
    check_eq(name, expected, stat);
  endtask

  // wait for a tick and compare line out and both interrupts
  task automatic wait_tick();
    do begin
      step();
    end while (!tick_seen);
    step();
    step();                                     // irq lands one edge after the count
    check_eq("line out", (play_q.size() == 0) ? '0 : play_q[0], line_out);
    check_eq("play irq", play_irq_m, irq_play);
    check_eq("rec irq", rec_irq_m, irq_rec);
  endtask

  //------------------------------------------------------------
  // run limit

  always @(posedge clk_adc_125mhz) begin
    run_cycles <= run_cycles + 1;
    if (run_cycles == TIMEOUT) begin
      $display("Simulation failed");
      $fatal(1, "run timed out after %0d clock cycles", TIMEOUT);
    end
  end

  initial begin
    ac97_pkg::bus_data_t stat;
    ac97_pkg::bus_data_t rdata;
    int                  n;
    rng_state    = 32'h832e6933;
    play_left_m  = '0;
    play_right_m = 1'b0;
    rec_right_m  = 1'b0;
    play_irq_m   = 1'b0;
    rec_irq_m    = 1'b0;
    underrun_m   = 1'b0;
    overrun_m    = 1'b0;
    tick_seen    = 1'b0;
    sys_addr    <= '0;
    sys_wdata   <= '0;
    sys_sel     <= 4'hf;
    sys_wen     <= 1'b0;
    sys_ren     <= 1'b0;
    line_in     <= '0;
    do begin
      step();
    end while (!adc_rstn);                      // first edge out of reset

    // tick timing with the long run first and then five short and one long
    count_to_tick(n);
    check_eq("first tick delay", SHORT + 1, n);
    check_eq("first 8k tick", 1, ac97_clks[0]);
    for (int k = 1; k <= 12; k++) begin
      count_to_tick(n);
      check_eq("tick gap", (k % RUNS == 0) ? SHORT + 1 : SHORT, n);
      check_eq("8k tick", (k % RUNS == 0), ac97_clks[0]);
    end

    // playback starting right after a tick
    write_reset(2'b11);
    read_status("status after clear", stat);
    for (int i = 0; i < 20; i++) begin
      rng_state = lcg(rng_state);
      write_play(rng_state);                    // alternating left and right
    end
    read_status("status after fill", stat);
    while (play_q.size() != 0) wait_tick();
    wait_tick();                                // tick on an empty play fifo
    read_status("status after drain", stat);
    check_eq("underrun bit", 1, stat[`STAT_PLAY_UNDERRUN]);

    // record fifo filled during the playback ticks
    check_eq("rec irq at half full", 1, irq_rec);
    while (rec_q.size() != 0) begin
      read_rec("rec left");
      read_rec("rec right");
    end
    read_status("status after rec drain", stat);
    check_eq("rec empty bit", 1, stat[`STAT_REC_EMPTY]);
    check_eq("rec irq after drain", 0, irq_rec);

    // overrun with no reads
    repeat (DEPTH + 1) wait_tick();
    read_status("status after overrun", stat);
    check_eq("rec full bit", 1, stat[`STAT_REC_FULL]);
    check_eq("overrun bit", 1, stat[`STAT_REC_OVERRUN]);

    // fifo reset with both irqs high and the rec phase left on right
    for (int i = 0; i < 2 * HALF; i++) begin
      rng_state = lcg(rng_state);
      write_play(rng_state);
    end
    wait_tick();                                // play count drops below half
    check_eq("play irq before reset", 1, irq_play);
    for (int i = 0; i < 2; i++) begin
      rng_state = lcg(rng_state);
      write_play(rng_state);                    // play back at half full
    end
    read_rec("rec left before reset");
    write_reset(2'b11);
    read_status("status after reset", stat);
    check_eq("play irq after reset", 0, irq_play);
    check_eq("rec irq after reset", 0, irq_rec);
    wait_tick();
    read_rec("rec left after reset");

    // bus rules
    bus_access(1'b0, 20'h00010, '0, "unmapped read", rdata);
    check_eq("unmapped read data", 0, rdata);
    bus_access(1'b0, `AC97_REG_FIFO_PLAY, '0, "play offset read", rdata);
    check_eq("play offset read data", 0, rdata);
    bus_access(1'b0, `AC97_REG_FIFO_RESET, '0, "reset offset read", rdata);
    check_eq("reset offset read data", 0, rdata);
    rng_state = lcg(rng_state);
    bus_access(1'b1, `AC97_REG_STAT, rng_state, "status write", rdata);
    read_status("status after write", stat);
    step();
    check_eq("ack while idle", 0, sys_ack);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int RESET_CYCLES = 8                // reset length in clock cycles
) (
  output logic clk_adc_125mhz_o,                // 8 ns period
  output logic adc_rstn_o                       // released on a rising edge
);

  initial begin
    clk_adc_125mhz_o = 1'b0;
    forever #4 clk_adc_125mhz_o = ~clk_adc_125mhz_o;
  end

  initial begin
    adc_rstn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_adc_125mhz_o);
    adc_rstn_o <= 1'b1;
  end

endmodule
